//--- common/scene_pkg.sv
`default_nettype none

package scene_pkg;

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [7:0]  color_t;
    typedef logic [3:0]  digit_t;
    typedef logic [8:0]  bus_addr_t;
    typedef logic [31:0] bus_data_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    typedef struct packed {
        digit_t  score;
        hcount_t x;
        vcount_t y;
    } overlay_cfg_t;

    typedef enum logic {
        phase_day,
        phase_night
    } sky_phase_e;

    // Horizontal timing, in clk cycles
    localparam hcount_t h_active = 11'd1280;
    localparam hcount_t h_front  = 11'd32;
    localparam hcount_t h_sync   = 11'd192;
    localparam hcount_t h_back   = 11'd96;
    localparam hcount_t h_total  = h_active + h_front + h_sync + h_back;

    // Vertical timing, in lines
    localparam vcount_t v_active = 10'd480;
    localparam vcount_t v_front  = 10'd10;
    localparam vcount_t v_sync   = 10'd2;
    localparam vcount_t v_back   = 10'd33;
    localparam vcount_t v_total  = v_active + v_front + v_sync + v_back;

    localparam vcount_t ground_row = 10'd280;
    localparam vcount_t stripe_row = 10'd400;

    localparam rgb_t sky_day      = '{r: 8'd135, g: 8'd206, b: 8'd235};
    localparam rgb_t sky_night    = '{r: 8'd10,  g: 8'd10,  b: 8'd40};
    localparam rgb_t ground_light = '{r: 8'd139, g: 8'd69,  b: 8'd19};
    localparam rgb_t ground_dark  = '{r: 8'd100, g: 8'd40,  b: 8'd10};
    localparam rgb_t line_color   = '{r: 8'd0,   g: 8'd0,   b: 8'd0};
    localparam rgb_t digit_color  = '{r: 8'd0,   g: 8'd0,   b: 8'd0};

    localparam int digit_size  = 8;
    localparam int digit_count = 10;

    // Row 0 on top, bit 7 is the leftmost column
    localparam logic [7:0] font_rows [0:digit_count-1][0:digit_size-1] = '{
        '{8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00},
        '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00},
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
        '{8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
        '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
        '{8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00},
        '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
        '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
        '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00}
    };

    // Register map
    localparam bus_addr_t reg_score   = 9'd0;
    localparam bus_addr_t reg_score_x = 9'd1;
    localparam bus_addr_t reg_score_y = 9'd2;

    localparam overlay_cfg_t cfg_reset = '{score: 4'd0, x: 11'd25, y: 10'd41};

endpackage

`default_nettype wire

//--- design/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import scene_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    output hcount_t hcount,
    output vcount_t vcount,
    output logic    hs,
    output logic    vs,
    output logic    blank_n,
    output logic    pix_clk
);

    logic end_of_line;
    logic end_of_frame;

    assign end_of_line  = (hcount == h_total - 11'd1);
    assign end_of_frame = (vcount == v_total - 10'd1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (end_of_line) begin
                hcount <= '0;
                // Next line, or back to the top
                vcount <= end_of_frame ? '0 : vcount + 10'd1;
            end else begin
                hcount <= hcount + 11'd1;
            end
        end
    end

    // Sync pulses are active low
    assign hs = !((hcount >= h_active + h_front) &&
                  (hcount <  h_active + h_front + h_sync));
    assign vs = !((vcount >= v_active + v_front) &&
                  (vcount <  v_active + v_front + v_sync));

    assign blank_n = (hcount < h_active) && (vcount < v_active);
    assign pix_clk = hcount[0];

    hcount_in_range: assert property (
        @(posedge clk) disable iff (reset) hcount < h_total
    ) else $error("hcount reached h_total");

endmodule

`default_nettype wire

//--- scene/scene_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scene_regs
    import scene_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         chipselect,
    input  logic         write,
    input  bus_addr_t    address,
    input  bus_data_t    writedata,
    output overlay_cfg_t cfg
);

    logic wr_en;

    assign wr_en = chipselect && write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg <= cfg_reset;
        end else if (wr_en) begin
            case (address)
                reg_score: begin
                    cfg.score <= writedata[3:0];
                end
                reg_score_x: begin
                    cfg.x <= writedata[10:0];
                end
                reg_score_y: begin
                    cfg.y <= writedata[9:0];
                end
                default: begin
                    // Unmapped address, write dropped
                end
            endcase
        end
    end

    unmapped_write: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> (address <= reg_score_y)
    ) else $warning("write to unmapped address %0d", address);

endmodule

`default_nettype wire

//--- scene/day_night_clock.sv
`timescale 1ns/1ps
`default_nettype none

module day_night_clock
    import scene_pkg::*;
#(
    parameter int unsigned day_length = 50_000_000
) (
    input  logic clk,
    input  logic reset,
    output rgb_t sky
);

    localparam int timer_w = $clog2(2 * day_length);

    typedef logic [timer_w-1:0] timer_t;

    localparam timer_t day_end    = timer_t'(day_length - 1);
    localparam timer_t period_end = timer_t'(2 * day_length - 1);

    timer_t     timer;
    sky_phase_e phase;

    // Phase flips together with the timer crossing day_length
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer <= '0;
            phase <= phase_day;
        end else begin
            if (timer == period_end) begin
                timer <= '0;
                phase <= phase_day;
            end else begin
                timer <= timer + 1'b1;
                if (timer == day_end)
                    phase <= phase_night;
            end
        end
    end

    assign sky = (phase == phase_night) ? sky_night : sky_day;

    timer_in_period: assert property (
        @(posedge clk) disable iff (reset) timer <= period_end
    ) else $error("day/night timer left its period");

endmodule

`default_nettype wire

//--- scene/score_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module score_overlay
    import scene_pkg::*;
(
    input  hcount_t      hcount,
    input  vcount_t      vcount,
    input  overlay_cfg_t cfg,
    output logic         digit_hit
);

    hcount_t    dx;
    vcount_t    dy;
    logic       in_box;
    logic       valid_digit;
    logic [7:0] row_bits;
    logic [2:0] row;
    logic [2:0] col;

    // Offsets into the glyph box
    assign dx = hcount - cfg.x;
    assign dy = vcount - cfg.y;

    // Explicit lower bounds, the subtraction may wrap
    assign in_box = (hcount >= cfg.x) && (dx < digit_size) &&
                    (vcount >= cfg.y) && (dy < digit_size);

    assign valid_digit = (cfg.score < digit_count);

    assign row = dy[2:0];
    assign col = dx[2:0];

    always_comb begin
        row_bits = 8'h00;
        if (valid_digit)
            row_bits = font_rows[cfg.score][row];
    end

    // Leftmost column sits in bit 7
    assign digit_hit = in_box && row_bits[3'd7 - col];

endmodule

`default_nettype wire

//--- scene/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer
    import scene_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  hcount_t hcount,
    input  vcount_t vcount,
    input  logic    blank_n,
    input  rgb_t    sky,
    input  logic    digit_hit,
    output rgb_t    pixel
);

    rgb_t background;
    rgb_t mixed;

    // Background bands by row
    always_comb begin
        if (vcount == ground_row)
            background = line_color;
        else if (vcount < ground_row)
            background = sky;
        else if (vcount < stripe_row)
            background = ground_light;
        else
            background = ground_dark;
    end

    assign mixed = digit_hit ? digit_color : background;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pixel <= '0;
        else if (blank_n)
            pixel <= mixed;
        else
            pixel <= '0;
    end

endmodule

`default_nettype wire

//--- design/scene_top.sv
`timescale 1ns/1ps
`default_nettype none

module scene_top
    import scene_pkg::*;
#(
    parameter int unsigned day_length = 50_000_000
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      chipselect,
    input  logic      write,
    input  bus_addr_t address,
    input  bus_data_t writedata,
    output color_t    vga_r,
    output color_t    vga_g,
    output color_t    vga_b,
    output logic      vga_hs,
    output logic      vga_vs,
    output logic      vga_blank_n,
    output logic      vga_sync_n,
    output logic      vga_clk
);

    hcount_t      hcount;
    vcount_t      vcount;
    logic         blank_n;
    overlay_cfg_t overlay_cfg;
    rgb_t         sky;
    logic         digit_hit;
    rgb_t         pixel;

    vga_timing timing0 (
        .clk     (clk),
        .reset   (reset),
        .hcount  (hcount),
        .vcount  (vcount),
        .hs      (vga_hs),
        .vs      (vga_vs),
        .blank_n (blank_n),
        .pix_clk (vga_clk)
    );

    scene_regs regs0 (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .cfg        (overlay_cfg)
    );

    day_night_clock #(
        .day_length (day_length)
    ) sky_clock0 (
        .clk   (clk),
        .reset (reset),
        .sky   (sky)
    );

    score_overlay overlay0 (
        .hcount    (hcount),
        .vcount    (vcount),
        .cfg       (overlay_cfg),
        .digit_hit (digit_hit)
    );

    pixel_mixer mixer0 (
        .clk       (clk),
        .reset     (reset),
        .hcount    (hcount),
        .vcount    (vcount),
        .blank_n   (blank_n),
        .sky       (sky),
        .digit_hit (digit_hit),
        .pixel     (pixel)
    );

    assign vga_blank_n = blank_n;
    assign vga_sync_n  = 1'b0;

    assign vga_r = pixel.r;
    assign vga_g = pixel.g;
    assign vga_b = pixel.b;

endmodule

`default_nettype wire

//--- bench/scene_tb.sv
`timescale 1ns/1ps
`default_nettype none

module scene_tb
    import scene_pkg::*;
();

    localparam int     day_len     = 100_000;
    localparam longint frame       = longint'(h_total) * longint'(v_total);
    localparam longint watchdog_ns = 5 * frame * 10;
    localparam longint hs_start    = h_active + h_front;
    localparam longint hs_end      = h_active + h_front + h_sync;
    localparam longint vs_start    = v_active + v_front;
    localparam longint vs_end      = v_active + v_front + v_sync;

    logic      clk = 1'b0;
    logic      reset;
    logic      chipselect;
    logic      write;
    bus_addr_t address;
    bus_data_t writedata;
    color_t    vga_r;
    color_t    vga_g;
    color_t    vga_b;
    logic      vga_hs;
    logic      vga_vs;
    logic      vga_blank_n;
    logic      vga_sync_n;
    logic      vga_clk;

    // Raster position model counting clk edges since reset release
    longint cyc = 0;
    string  test_name = "none";
    int     model_score = cfg_reset.score;
    longint model_x = cfg_reset.x;
    longint model_y = cfg_reset.y;

    scene_top #(
        .day_length (day_len)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n),
        .vga_clk     (vga_clk)
    );

    always #5 clk = ~clk;

    always @(posedge clk or posedge reset) begin
        if (reset)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before all tests finished");
        $display("Test failed");
        $fatal(1);
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic rgb_t sky_at(input longint m);
        if ((m % (2 * day_len)) >= day_len)
            return sky_night;
        return sky_day;
    endfunction

    function automatic bit font_lit(input longint m);
        longint     dx;
        longint     dy;
        logic [7:0] bits;
        dx = (m % h_total) - model_x;
        dy = ((m / h_total) % v_total) - model_y;
        if (model_score >= digit_count)
            return 1'b0;
        if (dx < 0 || dx >= digit_size || dy < 0 || dy >= digit_size)
            return 1'b0;
        bits = font_rows[model_score][dy];
        return bits[7 - dx];
    endfunction

    function automatic rgb_t expected_pixel(input longint m);
        longint h;
        longint v;
        h = m % h_total;
        v = (m / h_total) % v_total;
        if (h >= h_active || v >= v_active)
            return '0;
        if (font_lit(m))
            return digit_color;
        if (v == ground_row)
            return line_color;
        if (v < ground_row)
            return sky_at(m);
        if (v < stripe_row)
            return ground_light;
        return ground_dark;
    endfunction

    // First frame start that puts the given offset safely in the future
    function automatic longint next_frame_base(input longint offset);
        longint fs;
        fs = (cyc / frame) * frame;
        if (fs + offset <= cyc + 2)
            fs = fs + frame;
        return fs;
    endfunction

    function automatic longint find_sky_cycle(input longint from, input bit night);
        longint m;
        longint t;
        bit     found;
        m = from - 1;
        found = 1'b0;
        while (!found) begin
            m = m + 1;
            t = m % (2 * day_len);
            found = ((m % h_total) < h_active) && (((m / h_total) % v_total) < ground_row) &&
                    !font_lit(m) &&
                    (night ? (t >= day_len + day_len / 4 && t < 2 * day_len - day_len / 4)
                           : (t >= day_len / 4 && t < day_len - day_len / 4));
        end
        return m;
    endfunction

    task automatic run_to(input longint n);
        if (cyc > n) begin
            $display("Sample point at cycle %0d was already passed", n);
            $display("Test failed");
            $fatal(1);
        end
        while (cyc < n)
            @(negedge clk);
    endtask

    // Colour for position m shows up one cycle later
    task automatic check_pixel_at(input string what, input longint m, input rgb_t expected);
        run_to(m + 1);
        check_value(what, {8'h00, expected}, {8'h00, vga_r, vga_g, vga_b});
    endtask

    task automatic bus_write(input logic cs, input bus_addr_t addr, input bus_data_t data);
        @(posedge clk);
        #1;
        chipselect = cs;
        write      = 1'b1;
        address    = addr;
        writedata  = data;
        @(posedge clk);
        #1;
        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
    endtask

    task automatic check_box(input string what);
        longint fs;
        longint m;
        fs = next_frame_base(model_y * h_total + model_x);
        for (int r = 0; r < digit_size; r++) begin
            for (int c = 0; c < digit_size; c++) begin
                m = fs + (model_y + r) * h_total + model_x + c;
                check_pixel_at(what, m, expected_pixel(m));
            end
        end
    endtask

    task automatic check_reset_outputs();
        check_value("rgb", 32'd0, {8'h00, vga_r, vga_g, vga_b});
        check_value("hs", 32'd1, vga_hs);
        check_value("vs", 32'd1, vga_vs);
        check_value("blank_n", 32'd1, vga_blank_n);
        check_value("sync_n", 32'd0, vga_sync_n);
    endtask

    task automatic test_reset_state();
        test_name = "reset_state";
        repeat (3) @(negedge clk);
        check_reset_outputs();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_reset_outputs();
    endtask

    task automatic test_raster_frame();
        longint h;
        longint v;
        longint hs_low;
        longint vs_low;
        longint active;
        rgb_t   exp_pix;
        test_name = "raster_frame";
        hs_low = 0;
        vs_low = 0;
        active = 0;
        repeat (frame) begin
            @(negedge clk);
            h = cyc % h_total;
            v = (cyc / h_total) % v_total;
            exp_pix = expected_pixel(cyc - 1);
            check_value("hs", !(h >= hs_start && h < hs_end), vga_hs);
            check_value("vs", !(v >= vs_start && v < vs_end), vga_vs);
            check_value("blank_n", (h < h_active) && (v < v_active), vga_blank_n);
            check_value("vga_clk", h[0], vga_clk);
            check_value("sync_n", 32'd0, vga_sync_n);
            check_value("pixel", {8'h00, exp_pix}, {8'h00, vga_r, vga_g, vga_b});
            hs_low = hs_low + (vga_hs == 1'b0);
            vs_low = vs_low + (vga_vs == 1'b0);
            active = active + (vga_blank_n == 1'b1);
        end
        check_value("hs low cycles", v_total * h_sync, hs_low);
        check_value("vs low cycles", v_sync * h_total, vs_low);
        check_value("active cycles", h_active * v_active, active);
    endtask

    task automatic test_background_bands();
        longint fs;
        test_name = "background_bands";
        bus_write(1'b1, reg_score_y, 32'd470);
        model_y = 470;
        fs = next_frame_base(100 * h_total + 640);
        check_pixel_at("sky row", fs + 100 * h_total + 640, sky_at(fs + 100 * h_total + 640));
        check_pixel_at("line row", fs + ground_row * h_total + 640, line_color);
        check_pixel_at("light ground", fs + 300 * h_total + 640, ground_light);
        check_pixel_at("dark ground", fs + 450 * h_total + 640, ground_dark);
        check_pixel_at("h blank", fs + 450 * h_total + 1400, '0);
        check_pixel_at("v blank", fs + 500 * h_total + 100, '0);
    endtask

    task automatic test_day_night();
        longint m;
        test_name = "day_night";
        m = find_sky_cycle(cyc + 2, 1'b0);
        check_pixel_at("day sky", m, sky_day);
        m = find_sky_cycle(cyc + 2, 1'b1);
        check_pixel_at("night sky", m, sky_night);
    endtask

    task automatic test_score_overlay();
        test_name = "score_overlay";
        bus_write(1'b1, reg_score, 32'd8);
        bus_write(1'b1, reg_score_x, 32'd400);
        bus_write(1'b1, reg_score_y, 32'd150);
        model_score = 8;
        model_x = 400;
        model_y = 150;
        check_box("digit 8");
        // Out of range digit leaves only background in the box
        bus_write(1'b1, reg_score, 32'd12);
        model_score = 12;
        check_box("digit 12");
    endtask

    task automatic test_write_qualification();
        test_name = "write_qualification";
        bus_write(1'b1, reg_score, 32'd8);
        model_score = 8;
        bus_write(1'b0, reg_score, 32'd3);
        bus_write(1'b0, reg_score_x, 32'd600);
        bus_write(1'b1, 9'd7, 32'd3);
        check_box("ignored writes");
    endtask

    initial begin
        reset      = 1'b1;
        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        test_reset_state();
        test_raster_frame();
        test_day_night();
        test_background_bands();
        test_score_overlay();
        test_write_qualification();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
common/scene_pkg.sv
design/vga_timing.sv
scene/scene_regs.sv
scene/day_night_clock.sv
scene/score_overlay.sv
scene/pixel_mixer.sv
design/scene_top.sv
bench/scene_tb.sv

//--- Bender.yml
package:
  name: scene

sources:
  - common/scene_pkg.sv
  - design/vga_timing.sv
  - scene/scene_regs.sv
  - scene/day_night_clock.sv
  - scene/score_overlay.sv
  - scene/pixel_mixer.sv
  - design/scene_top.sv
  - target: test
    files:
      - bench/scene_tb.sv
